// ==== recoveryPkg.sv ====
//********************
// Widths, Hsiao column table and port types for the ECC register file
// The data width is fixed at 32 bits with a 7-bit Hsiao SECDED code
// Address fields are sized for MaxAddrWidth and only the low bits are used
//********************

package recoveryPkg;

  localparam int unsigned DataWidth    = 32;
  localparam int unsigned ParityWidth  = 7;
  localparam int unsigned CodeWidth    = DataWidth + ParityWidth;
  localparam int unsigned MaxAddrWidth = 8;

  // Parity-check column of each data bit, all of weight three
  // Check bits own the unit columns, so every column here is distinct from them
  localparam logic [ParityWidth-1:0] HsiaoColumns [DataWidth] = '{
    7'h07, 7'h0B, 7'h13, 7'h23, 7'h43, 7'h0D, 7'h15, 7'h25,  // Bits 0 to 7
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0E,  // Bits 8 to 15
    7'h16, 7'h26, 7'h46, 7'h1A, 7'h2A, 7'h4A, 7'h32, 7'h52,  // Bits 16 to 23
    7'h62, 7'h1C, 7'h2C, 7'h4C, 7'h34, 7'h54, 7'h64, 7'h38   // Bits 24 to 31
  };

  typedef struct packed {
    logic [ParityWidth-1:0] parity;
    logic [DataWidth-1:0]   data;
  } codeFields_t;

  // A stored word seen either as one raw vector or as its parity and data fields
  typedef union packed {
    logic [CodeWidth-1:0] raw;
    codeFields_t          fields;
  } codeword_t;

  typedef struct packed {
    logic                    we;
    logic [MaxAddrWidth-1:0] waddr;
    logic [DataWidth-1:0]    wdata;
  } rfWrite_t;

  typedef struct packed {
    logic                    inject;
    logic [MaxAddrWidth-1:0] addr;
    logic [CodeWidth-1:0]    mask;
  } rfInject_t;

endpackage

// ==== hsiaoEncoder.sv ====
//********************
// Hsiao SECDED encoder from 32 data bits to a 39-bit codeword
// Purely combinational with no pipeline stage
//********************

`timescale 1ns/100ps

module hsiaoEncoder (
  input  logic [recoveryPkg::DataWidth-1:0] data_i,
  output recoveryPkg::codeword_t            code_o
);

  import recoveryPkg::*;

  logic [ParityWidth-1:0] parity;

  // Each data bit toggles the check bits named by its column
  always_comb begin
    parity = '0;
    for (int d = 0; d < DataWidth; d++) begin
      parity = parity ^ (HsiaoColumns[d] & {ParityWidth{data_i[d]}});
    end
  end

  // Check bits sit above the data in the stored word
  always_comb begin
    code_o.fields.parity = parity;
    code_o.fields.data   = data_i;
  end

endmodule

// ==== hsiaoDecoder.sv ====
//********************
// Hsiao SECDED decoder with single-bit correction
// Double errors are flagged and the data passes through uncorrected
// Some triple errors alias to single errors and are not detected as such
//********************

`timescale 1ns/100ps

module hsiaoDecoder (
  input  recoveryPkg::codeword_t            code_i,
  output logic [recoveryPkg::DataWidth-1:0] data_o,
  output logic                              single_o,
  output logic                              double_o
);

  import recoveryPkg::*;

  logic [DataWidth-1:0]   rawData;
  logic [ParityWidth-1:0] rawParity;
  logic [ParityWidth-1:0] calcParity;
  logic [ParityWidth-1:0] syndrome;
  logic [DataWidth-1:0]   flipMask;
  logic                   synNonZero;
  logic                   synOdd;

  assign rawData   = code_i.raw[DataWidth-1:0];
  assign rawParity = code_i.raw[CodeWidth-1:DataWidth];

  // Same parity tree as the encoder, built from the shared column table
  always_comb begin
    calcParity = '0;
    for (int d = 0; d < DataWidth; d++) begin
      calcParity = calcParity ^ (HsiaoColumns[d] & {ParityWidth{rawData[d]}});
    end
  end

  assign syndrome = calcParity ^ rawParity;

  // A syndrome equal to a data column points at the failing data bit
  // A unit syndrome matches no column since the error is in a check bit
  always_comb begin
    for (int d = 0; d < DataWidth; d++) begin
      flipMask[d] = (syndrome == HsiaoColumns[d]);
    end
  end

  assign synNonZero = |syndrome;
  assign synOdd     = ^syndrome;

  // Odd weight marks one flipped bit, even nonzero weight marks two
  assign single_o = synNonZero & synOdd;
  assign double_o = synNonZero & ~synOdd;

  assign data_o = single_o ? (rawData ^ flipMask) : rawData;

endmodule

// ==== rfStorage.sv ====
//********************
// Codeword array with one encoder per write port
// Word zero is never written and stays at the all-zero codeword
// The highest-numbered write port wins on an address clash
// A write to the injection address in the same cycle drops the injection
//********************

`timescale 1ns/100ps

module rfStorage #(
  parameter  int unsigned NumWrPorts = 2,
  parameter  int unsigned AddrWidth  = 5,
  localparam int unsigned NumWords   = 2 ** AddrWidth
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  recoveryPkg::rfWrite_t [NumWrPorts-1:0]    wr_i,
  input  recoveryPkg::rfInject_t                    inj_i,
  output recoveryPkg::codeword_t [NumWords-1:0]     codeMem_o
);

  import recoveryPkg::*;

  codeword_t [NumWrPorts-1:0]          wrCode;
  logic [NumWrPorts-1:0][NumWords-1:0] wrHit;
  logic [NumWords-1:0]                 wordWe;
  codeword_t [NumWords-1:0]            wordNext;
  logic [NumWords-1:0]                 injHit;

  for (genvar p = 0; p < NumWrPorts; p++) begin : genEncoders
    hsiaoEncoder hsiaoEncoder_i (
      .data_i ( wr_i[p].wdata ),
      .code_o ( wrCode[p]     )
    );

    for (genvar w = 0; w < NumWords; w++) begin : genDecode
      assign wrHit[p][w] = wr_i[p].we &&
                           (wr_i[p].waddr[AddrWidth-1:0] == AddrWidth'(w));
    end

    // Upper address bits must be clear, otherwise the write aliases a lower word
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      wr_i[p].we |-> (wr_i[p].waddr < NumWords))
      else $error("Write port %0d address out of range", p);
  end

  for (genvar w = 0; w < NumWords; w++) begin : genInject
    assign injHit[w] = inj_i.inject &&
                       (inj_i.addr[AddrWidth-1:0] == AddrWidth'(w));
  end

  // Later ports overwrite earlier ones, which gives the top port priority
  always_comb begin
    wordWe   = '0;
    wordNext = '0;
    for (int w = 0; w < NumWords; w++) begin
      for (int p = 0; p < NumWrPorts; p++) begin
        if (wrHit[p][w]) begin
          wordWe[w]   = 1'b1;
          wordNext[w] = wrCode[p];
        end
      end
    end
  end

  // The loop starts at word one so the zero word keeps its reset value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      codeMem_o <= '0;
    end else begin
      for (int w = 1; w < NumWords; w++) begin
        if (wordWe[w]) begin
          codeMem_o[w] <= wordNext[w];
        end else if (injHit[w]) begin
          codeMem_o[w].raw <= codeMem_o[w].raw ^ inj_i.mask;
        end
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    inj_i.inject |-> (inj_i.addr < NumWords))
    else $error("Injection address out of range");

endmodule

// ==== rfReadMux.sv ====
//********************
// Read-port selection and error summary over the corrected array
// Reads are combinational from address to data
// Flags are levels that stay high while any word is faulty
//********************

`timescale 1ns/100ps

module rfReadMux #(
  parameter  int unsigned NumRdPorts = 3,
  parameter  int unsigned AddrWidth  = 5,
  localparam int unsigned NumWords   = 2 ** AddrWidth
) (
  input  logic [NumWords-1:0][recoveryPkg::DataWidth-1:0]   dataCorr_i,
  input  logic [NumWords-1:0]                               single_i,
  input  logic [NumWords-1:0]                               double_i,
  input  logic [NumRdPorts-1:0][AddrWidth-1:0]              raddr_i,
  output logic [NumRdPorts-1:0][recoveryPkg::DataWidth-1:0] rdata_o,
  output logic [NumWords-1:0][recoveryPkg::DataWidth-1:0]   rfMem_o,
  output logic                                              errCorr_o,
  output logic                                              errUncorr_o
);

  // One full-width mux per read port
  for (genvar r = 0; r < NumRdPorts; r++) begin : genRdPorts
    assign rdata_o[r] = dataCorr_i[raddr_i[r]];
  end

  // Recovery reads every word at once, already corrected
  assign rfMem_o = dataCorr_i;

  // A word with a double error never also counts as correctable
  assign errCorr_o   = |single_i;
  assign errUncorr_o = |double_i;

endmodule

// ==== recoveryRf.sv ====
//********************
// ECC-protected multi-ported register file for state recovery
// Writes land at the clock edge and are visible one cycle later
// Reads, the snapshot and the flags are combinational from the array
// AddrWidth must not exceed the package address field width
//********************

`timescale 1ns/100ps

module recoveryRf #(
  parameter  int unsigned NumRdPorts = 3,
  parameter  int unsigned NumWrPorts = 2,
  parameter  int unsigned AddrWidth  = 5,
  localparam int unsigned NumWords   = 2 ** AddrWidth
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  recoveryPkg::rfWrite_t [NumWrPorts-1:0]            wr_i,
  input  recoveryPkg::rfInject_t                            inj_i,
  input  logic [NumRdPorts-1:0][AddrWidth-1:0]              raddr_i,
  output logic [NumRdPorts-1:0][recoveryPkg::DataWidth-1:0] rdata_o,
  output logic [NumWords-1:0][recoveryPkg::DataWidth-1:0]   rfMem_o,
  output logic                                              errCorr_o,
  output logic                                              errUncorr_o
);

  import recoveryPkg::*;

  codeword_t [NumWords-1:0]            codeMem;
  logic [NumWords-1:0][DataWidth-1:0]  dataCorr;
  logic [NumWords-1:0]                 single;
  logic [NumWords-1:0]                 double;

  // The only clocked stage in the design
  rfStorage #(
    .NumWrPorts ( NumWrPorts ),
    .AddrWidth  ( AddrWidth  )
  ) rfStorage_i (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .wr_i      ( wr_i    ),
    .inj_i     ( inj_i   ),
    .codeMem_o ( codeMem )
  );

  // Every stored word has its own decoder so the snapshot is always corrected
  for (genvar k = 0; k < NumWords; k++) begin : genDecoders
    hsiaoDecoder hsiaoDecoder_i (
      .code_i   ( codeMem[k]  ),
      .data_o   ( dataCorr[k] ),
      .single_o ( single[k]   ),
      .double_o ( double[k]   )
    );
  end

  rfReadMux #(
    .NumRdPorts ( NumRdPorts ),
    .AddrWidth  ( AddrWidth  )
  ) rfReadMux_i (
    .dataCorr_i  ( dataCorr    ),
    .single_i    ( single      ),
    .double_i    ( double      ),
    .raddr_i     ( raddr_i     ),
    .rdata_o     ( rdata_o     ),
    .rfMem_o     ( rfMem_o     ),
    .errCorr_o   ( errCorr_o   ),
    .errUncorr_o ( errUncorr_o )
  );

endmodule

// ==== tbClock.sv ====
//********************
// Free-running clock and active-low reset for the testbench
// Reset is released on a rising edge after ResetCycles edges
//********************

`timescale 1ns/100ps

module tbClock #(
  parameter int unsigned HalfPeriod  = 4,
  parameter int unsigned ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriod) clk_o = ~clk_o;
    end
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== tbRecoveryRf.sv ====
//********************
// Testbench for the ECC register file with a data and mask reference model
// Concurrent assertions compare every output with the model at each edge
// Injected masks are kept to at most two bits per word
//********************

`timescale 1ns/100ps

module tbRecoveryRf;

  import recoveryPkg::*;

  localparam int unsigned NumRdPorts   = 3;
  localparam int unsigned NumWrPorts   = 2;
  localparam int unsigned AddrWidth    = 5;
  localparam int unsigned NumWords     = 2 ** AddrWidth;
  localparam int unsigned FlagTimeout  = 4;
  localparam int unsigned ResetTimeout = 10;

  typedef rfWrite_t [NumWrPorts-1:0]            wrBus_t;
  typedef logic [NumRdPorts-1:0][AddrWidth-1:0] rdAddr_t;

  localparam wrBus_t    NoWrite  = '0;
  localparam rfInject_t NoInject = '0;

  logic                               clk;
  logic                               rstN;
  wrBus_t                             wr;
  rfInject_t                          inj;
  rdAddr_t                            raddr;
  logic [NumRdPorts-1:0][DataWidth-1:0] rdata;
  logic [NumWords-1:0][DataWidth-1:0]   rfMem;
  logic                               errCorr;
  logic                               errUncorr;

  // Reference model: stored data plus the mask injected since the last write
  logic [DataWidth-1:0]                 modelData [NumWords];
  logic [CodeWidth-1:0]                 modelMask [NumWords];
  logic [NumWords-1:0][DataWidth-1:0]   expMem;
  logic [NumRdPorts-1:0][DataWidth-1:0] expRdata;
  logic                                 expCorr;
  logic                                 expUncorr;

  int errCount      = 0;
  int testsRun      = 0;
  int testsFailed   = 0;
  int testStartErrs = 0;
  bit resetSeen;

  tbClock #(
    .HalfPeriod  ( 4 ),
    .ResetCycles ( 2 )
  ) tbClock_i (
    .clk_o  ( clk  ),
    .rst_no ( rstN )
  );

  recoveryRf #(
    .NumRdPorts ( NumRdPorts ),
    .NumWrPorts ( NumWrPorts ),
    .AddrWidth  ( AddrWidth  )
  ) recoveryRf_i (
    .clk_i       ( clk       ),
    .rst_ni      ( rstN      ),
    .wr_i        ( wr        ),
    .inj_i       ( inj       ),
    .raddr_i     ( raddr     ),
    .rdata_o     ( rdata     ),
    .rfMem_o     ( rfMem     ),
    .errCorr_o   ( errCorr   ),
    .errUncorr_o ( errUncorr )
  );

  // Later ports are applied last, so the highest port wins a clash
  always @(posedge clk or negedge rstN) begin : updateModel
    logic [NumWords-1:0] written;
    if (!rstN) begin
      for (int w = 0; w < NumWords; w++) begin
        modelData[w] <= '0;
        modelMask[w] <= '0;
      end
    end else begin
      written = '0;
      for (int p = 0; p < NumWrPorts; p++) begin
        if (wr[p].we && wr[p].waddr != 0) begin
          modelData[wr[p].waddr[AddrWidth-1:0]] <= wr[p].wdata;
          modelMask[wr[p].waddr[AddrWidth-1:0]] <= '0;
          written[wr[p].waddr[AddrWidth-1:0]] = 1'b1;
        end
      end
      if (inj.inject && inj.addr != 0 && !written[inj.addr[AddrWidth-1:0]]) begin
        modelMask[inj.addr[AddrWidth-1:0]] <= modelMask[inj.addr[AddrWidth-1:0]] ^ inj.mask;
      end
    end
  end

  // One flipped bit is corrected, two flipped bits come back uncorrected
  always_comb begin : expectModel
    int weight;
    expCorr   = 1'b0;
    expUncorr = 1'b0;
    for (int w = 0; w < NumWords; w++) begin
      weight = $countones(modelMask[w]);
      expMem[w] = (weight == 2) ? (modelData[w] ^ modelMask[w][DataWidth-1:0]) : modelData[w];
      expCorr   = expCorr | (weight == 1);
      expUncorr = expUncorr | (weight == 2);
    end
    for (int r = 0; r < NumRdPorts; r++) begin
      expRdata[r] = expMem[raddr[r]];
    end
  end

  function automatic void noteFailure(input string msg);
    errCount++;
    $display("[FAIL] %0t ns %s", $time, msg);
  endfunction

  for (genvar r = 0; r < NumRdPorts; r++) begin : genReadChecks
    assert property (@(posedge clk) disable iff (!rstN) rdata[r] == expRdata[r])
      else noteFailure($sformatf("read port %0d addr %0d gave %h, expected %h",
                                 r, raddr[r], rdata[r], expRdata[r]));
    assert property (@(posedge clk) disable iff (!rstN) (raddr[r] == 0) |-> (rdata[r] == '0))
      else noteFailure($sformatf("read port %0d returned %h from word zero", r, rdata[r]));
  end

  assert property (@(posedge clk) disable iff (!rstN) rfMem == expMem)
    else noteFailure("recovery snapshot differs from the model array");

  assert property (@(posedge clk) disable iff (!rstN) errCorr == expCorr)
    else noteFailure($sformatf("errCorr is %b, expected %b", errCorr, expCorr));

  assert property (@(posedge clk) disable iff (!rstN) errUncorr == expUncorr)
    else noteFailure($sformatf("errUncorr is %b, expected %b", errUncorr, expUncorr));

  function automatic rfWrite_t makeWrite(input int unsigned addr,
                                         input logic [DataWidth-1:0] data);
    rfWrite_t w;
    w.we    = 1'b1;
    w.waddr = MaxAddrWidth'(addr);
    w.wdata = data;
    return w;
  endfunction

  function automatic rfInject_t makeInject(input int unsigned addr,
                                           input logic [CodeWidth-1:0] mask);
    rfInject_t i;
    i.inject = 1'b1;
    i.addr   = MaxAddrWidth'(addr);
    i.mask   = mask;
    return i;
  endfunction

  function automatic rdAddr_t allPorts(input int unsigned addr);
    rdAddr_t a;
    for (int r = 0; r < NumRdPorts; r++) begin
      a[r] = AddrWidth'(addr);
    end
    return a;
  endfunction

  function automatic rdAddr_t randomReads();
    rdAddr_t a;
    for (int r = 0; r < NumRdPorts; r++) begin
      a[r] = AddrWidth'($urandom_range(0, NumWords - 1));
    end
    return a;
  endfunction

  task automatic driveCycle(input wrBus_t wrVal, input rfInject_t injVal, input rdAddr_t rdVal);
    @(posedge clk);
    wr    <= wrVal;
    inj   <= injVal;
    raddr <= rdVal;
  endtask

  task automatic waitForReset(output bit seen);
    seen = 1'b0;
    for (int i = 0; i < ResetTimeout && !seen; i++) begin
      @(negedge clk);
      seen = rstN;
    end
  endtask

  // Flags are sampled on the falling edge where they are settled
  task automatic waitForFlags(input logic wantCorr, input logic wantUncorr, input string what);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < FlagTimeout && !seen; i++) begin
      @(negedge clk);
      seen = (errCorr == wantCorr) && (errUncorr == wantUncorr);
    end
    if (!seen) begin
      errCount++;
      $display("Timed out after %s: the error flags never reached corr %b uncorr %b",
               what, wantCorr, wantUncorr);
    end
  endtask

  task automatic finishTest(input string name);
    int errs;
    driveCycle(NoWrite, NoInject, randomReads());
    driveCycle(NoWrite, NoInject, randomReads());
    @(negedge clk);
    errs = errCount - testStartErrs;
    testStartErrs = errCount;
    testsRun++;
    if (errs != 0) begin
      testsFailed++;
    end
    $display("Test %-22s %s with %0d errors", name, (errs == 0) ? "ok" : "bad", errs);
  endtask

  task automatic idleAfterReset();
    for (int i = 0; i < 6; i++) begin
      driveCycle(NoWrite, NoInject, randomReads());
    end
    waitForFlags(1'b0, 1'b0, "reset");
  endtask

  task automatic mixedWriteRead();
    wrBus_t  wrVal;
    rdAddr_t rdVal;
    int unsigned addr;
    rdVal = randomReads();
    for (int i = 0; i < 48; i++) begin
      for (int p = 0; p < NumWrPorts; p++) begin
        // Every few cycles a port aims at word zero, which must stay zero
        addr = (i % 6 == p) ? 0 : $urandom_range(0, NumWords - 1);
        wrVal[p] = makeWrite(addr, $urandom);
        wrVal[p].we = ($urandom_range(0, 3) != 0);
      end
      driveCycle(wrVal, NoInject, rdVal);
      rdVal[0] = wrVal[0].waddr[AddrWidth-1:0];
      rdVal[1] = wrVal[1].waddr[AddrWidth-1:0];
      rdVal[2] = (i % 2 == 0) ? '0 : AddrWidth'($urandom_range(0, NumWords - 1));
    end
    driveCycle(NoWrite, NoInject, rdVal);
  endtask

  task automatic portClash();
    wrBus_t wrVal;
    int unsigned addr;
    for (int i = 0; i < 8; i++) begin
      addr = $urandom_range(1, NumWords - 1);
      for (int p = 0; p < NumWrPorts; p++) begin
        wrVal[p] = makeWrite(addr, $urandom);
      end
      driveCycle(wrVal, NoInject, randomReads());
      driveCycle(NoWrite, NoInject, allPorts(addr));
    end
  endtask

  task automatic singleBitFault(input int unsigned bitLo, input int unsigned bitHi);
    wrBus_t wrVal;
    logic [CodeWidth-1:0] mask;
    int unsigned addr;
    for (int i = 0; i < 3; i++) begin
      addr  = $urandom_range(1, NumWords - 1);
      wrVal = NoWrite;
      wrVal[0] = makeWrite(addr, $urandom);
      mask = '0;
      mask[$urandom_range(bitLo, bitHi)] = 1'b1;
      driveCycle(wrVal, NoInject, allPorts(addr));
      driveCycle(NoWrite, makeInject(addr, mask), allPorts(addr));
      driveCycle(NoWrite, NoInject, allPorts(addr));
      waitForFlags(1'b1, 1'b0, "a single-bit injection");
      // A fresh write replaces the faulty codeword
      wrVal[0].wdata = $urandom;
      driveCycle(wrVal, NoInject, allPorts(addr));
      driveCycle(NoWrite, NoInject, allPorts(addr));
      waitForFlags(1'b0, 1'b0, "rewriting a corrected word");
    end
  endtask

  task automatic doubleBitFault();
    wrBus_t wrVal;
    logic [CodeWidth-1:0] mask;
    int unsigned addr;
    int unsigned bitA;
    for (int i = 0; i < 4; i++) begin
      addr  = $urandom_range(1, NumWords - 1);
      bitA  = $urandom_range(0, CodeWidth - 1);
      wrVal = NoWrite;
      wrVal[1] = makeWrite(addr, $urandom);
      mask = '0;
      mask[bitA] = 1'b1;
      mask[(bitA + $urandom_range(1, CodeWidth - 1)) % CodeWidth] = 1'b1;
      driveCycle(wrVal, NoInject, allPorts(addr));
      driveCycle(NoWrite, makeInject(addr, mask), allPorts(addr));
      driveCycle(NoWrite, NoInject, allPorts(addr));
      waitForFlags(1'b0, 1'b1, "a two-bit injection");
      driveCycle(wrVal, NoInject, allPorts(addr));
      driveCycle(NoWrite, NoInject, allPorts(addr));
      waitForFlags(1'b0, 1'b0, "rewriting an uncorrectable word");
    end
  endtask

  task automatic overwriteInjection();
    wrBus_t wrVal;
    logic [CodeWidth-1:0] mask;
    int unsigned addr;
    for (int i = 0; i < 4; i++) begin
      addr  = $urandom_range(1, NumWords - 1);
      wrVal = NoWrite;
      wrVal[NumWrPorts-1] = makeWrite(addr, $urandom);
      mask = '0;
      mask[$urandom_range(0, CodeWidth - 1)] = 1'b1;
      driveCycle(wrVal, makeInject(addr, mask), allPorts(addr));
      driveCycle(NoWrite, NoInject, allPorts(addr));
      waitForFlags(1'b0, 1'b0, "a write over an injection");
    end
    // Word zero ignores injection as well
    driveCycle(NoWrite, makeInject(0, 39'h3), allPorts(0));
    driveCycle(NoWrite, NoInject, allPorts(0));
    waitForFlags(1'b0, 1'b0, "an injection into word zero");
  endtask

  initial begin
    wr    = NoWrite;
    inj   = NoInject;
    raddr = '0;
    void'($urandom(32));
    waitForReset(resetSeen);
    if (resetSeen) begin
      idleAfterReset();
      finishTest("reset");
      mixedWriteRead();
      finishTest("write and read-back");
      portClash();
      finishTest("port priority");
      singleBitFault(0, DataWidth - 1);
      finishTest("single data bit");
      singleBitFault(DataWidth, CodeWidth - 1);
      finishTest("single check bit");
      doubleBitFault();
      finishTest("double error");
      overwriteInjection();
      finishTest("write over injection");
    end else begin
      errCount++;
      $display("Reset was never released within %0d cycles", ResetTimeout);
    end
    $display("Tests run %0d, tests failed %0d, check failures %0d",
             testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
recoveryPkg.sv
hsiaoEncoder.sv
hsiaoDecoder.sv
rfStorage.sv
rfReadMux.sv
recoveryRf.sv
tbClock.sv
tbRecoveryRf.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the register file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tbRecoveryRf \
    -f vlog.f -o simRecoveryRf; then
  echo "Verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/simRecoveryRf); then
  echo "$output"
  echo "Simulation exited with an error status"
  exit 1
fi

echo "$output"

if echo "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
